//--- common/bus_pkg.sv
package bus_pkg;

	// byte address and data word widths shared by both cache ports
	localparam int ADDR_W = 32;
	localparam int WORD_W = 32;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;

	// arbiter FSM, two bits wide
	typedef enum logic [1:0] {
		idle     = 2'd0, // no grant, forwards winner combinationally
		irequest = 2'd1, // icache holds the grant
		drequest = 2'd2  // dcache holds the grant
	} arb_state_t;

endpackage

//--- common/mem_pkg.sv
package mem_pkg;

	localparam int MEM_WORDS = 256; // depth in words
	localparam int IDX_W = $clog2(MEM_WORDS); // word index from addr[9:2]

	// cycles a request is held before completion, at least 2
	localparam int MEM_LATENCY = 3;
	localparam int CNT_W = $clog2(MEM_LATENCY);
	localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(MEM_LATENCY - 1);

	// byte address to word index, low two bits dropped
	function automatic logic [IDX_W-1:0] word_idx(input logic [bus_pkg::ADDR_W-1:0] addr);
		return addr[IDX_W+1:2];
	endfunction

endpackage

//--- rtl/ram_controller.sv
`timescale 1ns/1ns

module ram_controller (
	input  logic            CLK,
	input  logic            arst_n,
	input  logic            ren,
	input  logic            wen,
	input  bus_pkg::addr_t  addr,
	input  bus_pkg::word_t  wdata,
	output logic            busy,
	output bus_pkg::word_t  rdata
);

	bus_pkg::word_t mem_array [mem_pkg::MEM_WORDS];

	logic [mem_pkg::CNT_W-1:0] wait_cnt;
	logic [mem_pkg::IDX_W-1:0] idx;
	logic                      active;
	logic                      done;

	assign idx    = mem_pkg::word_idx(addr);
	assign active = ren | wen;

	// last wait cycle is the completion cycle
	assign done = active && (wait_cnt == mem_pkg::LAST_CNT);
	assign busy = ~done;

	// read data only shows up when a read completes
	assign rdata = (ren && !wen && done) ? mem_array[idx] : '0;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wait_cnt <= '0;
		end else if (!active || done) begin
			wait_cnt <= '0; // restart for the next access
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	// array write lands at the edge ending the completion cycle
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
				mem_array[i] <= '0;
			end
		end else if (wen && done) begin
			mem_array[idx] <= wdata;
		end
	end

endmodule

//--- memory_arbiter/memory_arbiter.sv
`timescale 1ns/1ns

module memory_arbiter (
	input  logic            CLK,
	input  logic            arst_n,

	input  logic            icache_ren,
	input  logic            icache_wen,
	input  bus_pkg::addr_t  icache_addr,
	input  bus_pkg::word_t  icache_wdata,
	output logic            icache_busy,
	output bus_pkg::word_t  icache_rdata,

	input  logic            dcache_ren,
	input  logic            dcache_wen,
	input  bus_pkg::addr_t  dcache_addr,
	input  bus_pkg::word_t  dcache_wdata,
	output logic            dcache_busy,
	output bus_pkg::word_t  dcache_rdata,

	output logic            mem_ren,
	output logic            mem_wen,
	output bus_pkg::addr_t  mem_addr,
	output bus_pkg::word_t  mem_wdata,
	input  logic            mem_busy,
	input  bus_pkg::word_t  mem_rdata
);

	bus_pkg::arb_state_t state, next_state;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= bus_pkg::idle;
		end else begin
			state <= next_state;
		end
	end

	// request steering and response return
	always_comb begin
		icache_busy  = 1'b1; // both ports stall unless granted and done
		dcache_busy  = 1'b1;
		icache_rdata = '0;
		dcache_rdata = '0;
		mem_ren      = 1'b0;
		mem_wen      = 1'b0;
		mem_addr     = '0;
		mem_wdata    = '0;

		case (state)
			bus_pkg::idle: begin
				// fixed priority: dwrite, dread, iread, iwrite
				if (dcache_wen) begin
					mem_wen   = 1'b1;
					mem_addr  = dcache_addr;
					mem_wdata = dcache_wdata;
				end else if (dcache_ren) begin
					mem_ren  = 1'b1;
					mem_addr = dcache_addr;
				end else if (icache_ren) begin
					mem_ren  = 1'b1;
					mem_addr = icache_addr;
				end else if (icache_wen) begin
					mem_wen   = 1'b1;
					mem_addr  = icache_addr;
					mem_wdata = icache_wdata;
				end
			end

			bus_pkg::irequest: begin
				mem_addr = icache_addr;
				if (icache_wen) begin
					mem_wen   = 1'b1;
					mem_wdata = icache_wdata;
				end else begin
					mem_ren = 1'b1;
				end

				if (!mem_busy) begin
					icache_busy = 1'b0; // completion cycle
					if (!icache_wen) begin
						icache_rdata = mem_rdata;
					end
				end
			end

			bus_pkg::drequest: begin
				mem_addr = dcache_addr;
				if (dcache_wen) begin
					mem_wen   = 1'b1;
					mem_wdata = dcache_wdata;
				end else begin
					mem_ren = 1'b1;
				end

				if (!mem_busy) begin
					dcache_busy = 1'b0;
					if (!dcache_wen) begin
						dcache_rdata = mem_rdata;
					end
				end
			end

			default: begin
				// unused encoding, outputs stay at defaults
			end
		endcase
	end

	// next state
	always_comb begin
		next_state = state;

		case (state)
			bus_pkg::idle: begin
				if (dcache_wen || dcache_ren) begin
					next_state = bus_pkg::drequest;
				end else if (icache_ren || icache_wen) begin
					next_state = bus_pkg::irequest;
				end
			end

			bus_pkg::irequest,
			bus_pkg::drequest: begin
				if (!mem_busy) begin
					next_state = bus_pkg::idle; // grant released after completion
				end
			end

			default: next_state = bus_pkg::idle;
		endcase
	end

endmodule

//--- rtl/mem_subsystem_top.sv
`timescale 1ns/1ns

module mem_subsystem_top (
	input  logic            CLK,
	input  logic            arst_n,

	// instruction side
	input  logic            icache_ren,
	input  logic            icache_wen,
	input  bus_pkg::addr_t  icache_addr,
	input  bus_pkg::word_t  icache_wdata,
	output logic            icache_busy,
	output bus_pkg::word_t  icache_rdata,

	// data side
	input  logic            dcache_ren,
	input  logic            dcache_wen,
	input  bus_pkg::addr_t  dcache_addr,
	input  bus_pkg::word_t  dcache_wdata,
	output logic            dcache_busy,
	output bus_pkg::word_t  dcache_rdata
);

	// arbiter to RAM
	logic           mem_ren;
	logic           mem_wen;
	bus_pkg::addr_t mem_addr;
	bus_pkg::word_t mem_wdata;
	logic           mem_busy;
	bus_pkg::word_t mem_rdata;

	memory_arbiter u_arb (
		.CLK          (CLK),
		.arst_n       (arst_n),
		.icache_ren   (icache_ren),
		.icache_wen   (icache_wen),
		.icache_addr  (icache_addr),
		.icache_wdata (icache_wdata),
		.icache_busy  (icache_busy),
		.icache_rdata (icache_rdata),
		.dcache_ren   (dcache_ren),
		.dcache_wen   (dcache_wen),
		.dcache_addr  (dcache_addr),
		.dcache_wdata (dcache_wdata),
		.dcache_busy  (dcache_busy),
		.dcache_rdata (dcache_rdata),
		.mem_ren      (mem_ren),
		.mem_wen      (mem_wen),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.mem_busy     (mem_busy),
		.mem_rdata    (mem_rdata)
	);

	ram_controller u_ram (
		.CLK    (CLK),
		.arst_n (arst_n),
		.ren    (mem_ren),
		.wen    (mem_wen),
		.addr   (mem_addr),
		.wdata  (mem_wdata),
		.busy   (mem_busy),
		.rdata  (mem_rdata)
	);

endmodule

//--- tests/memory_arbiter_chk.sv
`timescale 1ns/1ns

module memory_arbiter_chk (
	input logic                CLK,
	input logic                arst_n,
	input logic                icache_busy,
	input logic                dcache_busy,
	input logic                mem_ren,
	input logic                mem_wen,
	input logic                mem_busy,
	input bus_pkg::arb_state_t state
);

	int   req_cycles;          // cycles spent in the current request state
	logic fail_excl = 1'b0;
	logic fail_both = 1'b0;
	logic fail_busy = 1'b0;
	logic fail_hold = 1'b0;
	logic any_failed;

	assign any_failed = fail_excl | fail_both | fail_busy | fail_hold;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			req_cycles <= 0;
		end else if (state == bus_pkg::idle) begin
			req_cycles <= 0;
		end else begin
			req_cycles <= req_cycles + 1;
		end
	end

	excl_ren_wen: assert property (@(posedge CLK) disable iff (!arst_n)
		!(mem_ren && mem_wen))
		else begin
			fail_excl = 1'b1;
			$error("mem_ren and mem_wen high together");
		end

	one_port_done: assert property (@(posedge CLK) disable iff (!arst_n)
		!(!icache_busy && !dcache_busy))
		else begin
			fail_both = 1'b1;
			$error("icache_busy and dcache_busy low together");
		end

	busy_follows_mem: assert property (@(posedge CLK) disable iff (!arst_n)
		(!icache_busy || !dcache_busy) |-> !mem_busy)
		else begin
			fail_busy = 1'b1;
			$error("port busy low while mem_busy high");
		end

	// idle forward cycle plus request state span the RAM latency
	hold_limit: assert property (@(posedge CLK) disable iff (!arst_n)
		(state != bus_pkg::idle) |-> (req_cycles < mem_pkg::MEM_LATENCY - 1))
		else begin
			fail_hold = 1'b1;
			$error("request state held longer than the memory latency");
		end

endmodule

bind memory_arbiter memory_arbiter_chk arb_chk (
	.CLK         (CLK),
	.arst_n      (arst_n),
	.icache_busy (icache_busy),
	.dcache_busy (dcache_busy),
	.mem_ren     (mem_ren),
	.mem_wen     (mem_wen),
	.mem_busy    (mem_busy),
	.state       (state)
);

//--- tests/tb_mem_subsystem.sv
`timescale 1ns/1ns

module tb_mem_subsystem;

	localparam logic [1:0] USE_I    = 2'd0;
	localparam logic [1:0] USE_D    = 2'd1;
	localparam logic [1:0] USE_BOTH = 2'd2;
	localparam int TIMEOUT_CYCLES   = 20;
	localparam int RANDOM_ENTRIES   = 40;

	typedef struct packed {
		logic [1:0]     use_ports; // icache only, dcache only or both
		logic           i_write;
		bus_pkg::addr_t i_addr;
		bus_pkg::word_t i_wdata;
		logic           d_write;
		bus_pkg::addr_t d_addr;
		bus_pkg::word_t d_wdata;
	} entry_t;

	logic           clk;
	logic           arst_n;
	logic           icache_ren;
	logic           icache_wen;
	bus_pkg::addr_t icache_addr;
	bus_pkg::word_t icache_wdata;
	logic           icache_busy;
	bus_pkg::word_t icache_rdata;
	logic           dcache_ren;
	logic           dcache_wen;
	bus_pkg::addr_t dcache_addr;
	bus_pkg::word_t dcache_wdata;
	logic           dcache_busy;
	bus_pkg::word_t dcache_rdata;

	bus_pkg::word_t model_mem [mem_pkg::MEM_WORDS]; // mirror of the RAM array
	entry_t         table_q [$];

	mem_subsystem_top UUT (
		.CLK          (clk),
		.arst_n       (arst_n),
		.icache_ren   (icache_ren),
		.icache_wen   (icache_wen),
		.icache_addr  (icache_addr),
		.icache_wdata (icache_wdata),
		.icache_busy  (icache_busy),
		.icache_rdata (icache_rdata),
		.dcache_ren   (dcache_ren),
		.dcache_wen   (dcache_wen),
		.dcache_addr  (dcache_addr),
		.dcache_wdata (dcache_wdata),
		.dcache_busy  (dcache_busy),
		.dcache_rdata (dcache_rdata)
	);

	always #4 clk = ~clk;

	always @(negedge clk) begin
		assert (!UUT.u_arb.arb_chk.any_failed)
			else report_failure("an assertion in the arbiter checker failed");
	end

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string name, input bus_pkg::word_t expected,
			input bus_pkg::word_t actual);
		assert (actual === expected) else begin
			report_failure($sformatf("CHECK FAILED at %0t ns: %s expected %h, got %h",
				$time, name, expected, actual));
		end
	endtask

	function automatic entry_t make_entry(input logic [1:0] use_ports, input logic i_write,
			input bus_pkg::addr_t i_addr, input bus_pkg::word_t i_wdata, input logic d_write,
			input bus_pkg::addr_t d_addr, input bus_pkg::word_t d_wdata);
		entry_t e;
		e.use_ports = use_ports;
		e.i_write   = i_write;
		e.i_addr    = i_addr;
		e.i_wdata   = i_wdata;
		e.d_write   = d_write;
		e.d_addr    = d_addr;
		e.d_wdata   = d_wdata;
		return e;
	endfunction

	// model update or read compare for one finished access
	task automatic complete_access(input string name, input logic is_write,
			input bus_pkg::addr_t addr, input bus_pkg::word_t wdata, input bus_pkg::word_t rdata);
		logic [mem_pkg::IDX_W-1:0] idx;
		idx = addr[mem_pkg::IDX_W+1:2]; // word index from bits 9 down to 2
		if (is_write) begin
			model_mem[idx] = wdata;
		end else begin
			check_value(name, model_mem[idx], rdata);
		end
	endtask

	task automatic run_entry(input entry_t e);
		bit i_pend;
		bit d_pend;
		bit i_now;
		bit d_now;
		int cycles;
		i_pend = (e.use_ports != USE_D);
		d_pend = (e.use_ports != USE_I);
		cycles = 0;
		@(posedge clk);
		#1;
		if (i_pend) begin
			icache_ren   = !e.i_write;
			icache_wen   = e.i_write;
			icache_addr  = e.i_addr;
			icache_wdata = e.i_wdata;
		end
		if (d_pend) begin
			dcache_ren   = !e.d_write;
			dcache_wen   = e.d_write;
			dcache_addr  = e.d_addr;
			dcache_wdata = e.d_wdata;
		end
		while (i_pend || d_pend) begin
			assert (cycles < TIMEOUT_CYCLES) else report_failure("timeout waiting for busy");
			@(negedge clk);
			d_now = d_pend && !dcache_busy;
			i_now = i_pend && !icache_busy;
			// dcache outranks icache for every operation
			assert (!(i_now && d_pend))
				else report_failure("icache finished while a dcache request was still waiting");
			if (d_now) begin
				complete_access("dcache_rdata", e.d_write, e.d_addr, e.d_wdata, dcache_rdata);
			end
			if (i_now) begin
				complete_access("icache_rdata", e.i_write, e.i_addr, e.i_wdata, icache_rdata);
			end
			@(posedge clk);
			#1;
			if (d_now) begin
				d_pend     = 1'b0;
				dcache_ren = 1'b0;
				dcache_wen = 1'b0;
			end
			if (i_now) begin
				i_pend     = 1'b0;
				icache_ren = 1'b0;
				icache_wen = 1'b0;
			end
			cycles++;
		end
	endtask

	initial begin
		entry_t rand_e;
		void'($urandom(47));
		clk          = 1'b0;
		arst_n       = 1'b0;
		icache_ren   = 1'b0;
		icache_wen   = 1'b0;
		icache_addr  = '0;
		icache_wdata = '0;
		dcache_ren   = 1'b0;
		dcache_wen   = 1'b0;
		dcache_addr  = '0;
		dcache_wdata = '0;
		for (int i = 0; i < mem_pkg::MEM_WORDS; i++) begin
			model_mem[i] = '0;
		end

		// directed part: dcache pair, icache pair, then shared requests
		table_q.push_back(make_entry(USE_D, 1'b0, '0, '0, 1'b1, 32'h100, 32'h1234_5678));
		table_q.push_back(make_entry(USE_D, 1'b0, '0, '0, 1'b0, 32'h100, '0));
		table_q.push_back(make_entry(USE_I, 1'b0, 32'h204, '0, 1'b0, '0, '0));
		table_q.push_back(make_entry(USE_I, 1'b1, 32'h208, 32'h0bad_f00d, 1'b0, '0, '0));
		table_q.push_back(make_entry(USE_I, 1'b0, 32'h208, '0, 1'b0, '0, '0));
		table_q.push_back(make_entry(USE_BOTH, 1'b0, 32'h30, '0, 1'b1, 32'h30, 32'hdead_beef));
		table_q.push_back(make_entry(USE_BOTH, 1'b1, 32'h30, 32'h5a5a_a5a5, 1'b0, 32'h208, '0));
		table_q.push_back(make_entry(USE_BOTH, 1'b0, 32'h100, '0, 1'b0, 32'h30, '0));
		for (int i = 0; i < RANDOM_ENTRIES; i++) begin
			rand_e.use_ports = 2'($urandom_range(0, 2));
			rand_e.i_write   = ($urandom_range(0, 1) != 0);
			rand_e.i_addr    = $urandom & 32'h0000_f03c; // 16 words, upper bits alias
			rand_e.i_wdata   = $urandom;
			rand_e.d_write   = ($urandom_range(0, 1) != 0);
			rand_e.d_addr    = $urandom & 32'h0000_f03c;
			rand_e.d_wdata   = $urandom;
			table_q.push_back(rand_e);
		end

		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		check_value("icache_busy", 32'd1, 32'(icache_busy));
		check_value("dcache_busy", 32'd1, 32'(dcache_busy));
		check_value("icache_rdata", '0, icache_rdata);
		check_value("dcache_rdata", '0, dcache_rdata);

		foreach (table_q[i]) begin
			run_entry(table_q[i]);
		end

		if (UUT.u_arb.arb_chk.any_failed) begin
			report_failure("an assertion in the arbiter checker failed");
		end else begin
			$display("test passed");
			$finish;
		end
	end

endmodule

//--- verilog.f
common/bus_pkg.sv
common/mem_pkg.sv
rtl/ram_controller.sv
memory_arbiter/memory_arbiter.sv
rtl/mem_subsystem_top.sv
tests/memory_arbiter_chk.sv
tests/tb_mem_subsystem.sv

//--- Makefile
# Verilator build and run for the shared-memory front end

VERILATOR ?= verilator
TOP       ?= tb_mem_subsystem
RTL_TOP   ?= mem_subsystem_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= test failed
PASS_MSG  ?= test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) common/bus_pkg.sv common/mem_pkg.sv \
		rtl/ram_controller.sv memory_arbiter/memory_arbiter.sv rtl/mem_subsystem_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
